/* subsys_defines.svh */
// Fixed 16-bit address and 32-bit data map; only regions 0 and 1 are mapped, word offsets only
`ifndef SUBSYS_DEFINES_SVH
`define SUBSYS_DEFINES_SVH

// ----------------------------------------
// Bus widths
`define SUBSYS_ADDR_W      16           // paddr width
`define SUBSYS_DATA_W      32           // pwdata / prdata width

// ----------------------------------------
// Address map
`define SUBSYS_REGION_MSB  15           // Region field, top nibble
`define SUBSYS_REGION_LSB  12
`define SUBSYS_OFFSET_MSB  11           // Word offset inside a region
`define SUBSYS_OFFSET_LSB  2
`define TIMER0_REGION      4'd0         // 0x0000 - 0x0fff
`define TIMER1_REGION      4'd1         // 0x1000 - 0x1fff

// Timer register word offsets
`define TIMER_CTRL_OFS     10'd0        // 0x00 control
`define TIMER_VALUE_OFS    10'd1        // 0x04 current count
`define TIMER_RELOAD_OFS   10'd2        // 0x08 reload value
`define TIMER_INTCLR_OFS   10'd3        // 0x0c flag read, write 1 clears

`endif

/* apb_pkg.sv */
// Bus types for the zero-wait APB subsystem; select vector has one spare bit for unmapped
`include "subsys_defines.svh"

package apb_pkg;

  // ----------------------------------------
  // Address and data
  typedef logic [`SUBSYS_ADDR_W-1:0] apb_addr_t;    // Full byte address
  typedef logic [`SUBSYS_DATA_W-1:0] apb_data_t;    // Read and write data

  // ----------------------------------------
  // Peripheral select, one-hot
  localparam int PSEL_TIMER0 = 0;                   // Region 0
  localparam int PSEL_TIMER1 = 1;                   // Region 1
  localparam int PSEL_NONE   = 2;                   // Any other region
  localparam int PSEL_W      = 3;

  typedef logic [PSEL_W-1:0] periph_sel_t;          // Zero when psel is low

endpackage

/* timer_pkg.sv */
// Timer types; control is 3 bits wide with enable in bit 0, ext_sel bit 1, irq_en bit 2
`include "subsys_defines.svh"

package timer_pkg;

  // ----------------------------------------
  // Control register fields
  // Listed MSB first so that enable lands in bit 0
  typedef struct packed {
    logic irq_en;                                    // Bit 2, flag may set on wrap
    logic ext_sel;                                   // Bit 1, count ext_in rising edges
    logic enable;                                    // Bit 0, counting on
  } timer_ctrl_t;

  // Counter value, same width as the bus
  typedef logic [`SUBSYS_DATA_W-1:0] timer_value_t;

  // ----------------------------------------
  // Subsystem interrupt vector
  localparam int NUM_TIMERS = 2;
  typedef logic [NUM_TIMERS-1:0] irq_vec_t;         // Bit 0 timer 0, bit 1 timer 1

endpackage

/* apb_decoder.sv */
// Purely combinational; any region other than the two timers selects the error slot
`timescale 1ns/1ns
`include "subsys_defines.svh"

module apb_decoder (
  input  logic                 psel,        // Host select
  input  logic [`SUBSYS_REGION_MSB-`SUBSYS_REGION_LSB:0] region,  // paddr[15:12]
  output apb_pkg::periph_sel_t sel          // One-hot, zero when idle
);
  import apb_pkg::*;

  always_comb
  begin
    sel = '0;                               // Idle, nothing selected
    if (psel)
    begin
      if (region == `TIMER0_REGION)
      begin
        sel[PSEL_TIMER0] = 1'b1;            // Timer 0
      end
      else if (region == `TIMER1_REGION)
      begin
        sel[PSEL_TIMER1] = 1'b1;            // Timer 1
      end
      else
      begin
        sel[PSEL_NONE] = 1'b1;              // Unmapped, mux returns error
      end
    end
  end

endmodule

/* apb_slave_mux.sv */
// Combinational return path; pslverr only asserts in the access phase of an unmapped transfer
`timescale 1ns/1ns

module apb_slave_mux (
  input  logic                 penable,         // Access phase
  input  apb_pkg::periph_sel_t sel,             // From decoder
  input  apb_pkg::apb_data_t   timer0_rd_data,  // Timer 0 read data
  input  apb_pkg::apb_data_t   timer1_rd_data,  // Timer 1 read data
  output apb_pkg::apb_data_t   prdata,          // To host
  output logic                 pslverr          // To host
);
  import apb_pkg::*;

  // ----------------------------------------
  // Read data
  always_comb
  begin
    prdata = '0;                                // Unmapped or idle reads zero
    if (sel[PSEL_TIMER0])
    begin
      prdata = timer0_rd_data;
    end
    else if (sel[PSEL_TIMER1])
    begin
      prdata = timer1_rd_data;
    end
  end

  // ----------------------------------------
  // Error response
  // Setup phase never flags, only the completing access phase
  always_comb
  begin
    pslverr = 1'b0;
    if (sel[PSEL_NONE] && penable)
    begin
      pslverr = 1'b1;                           // No slave at this region
    end
  end

endmodule

/* timer_counter.sv */
// Ext edges are counted three clocks late; pulses must stay high and low at least two clocks
`timescale 1ns/1ns

module timer_counter (
  input  logic                    pclk,        // Clock
  input  logic                    arst_n,      // Async reset, active low
  input  timer_pkg::timer_ctrl_t  ctrl,        // Enable and mode
  input  timer_pkg::timer_value_t reload,      // Loaded on wrap
  input  logic                    value_load,  // Bus write to VALUE
  input  timer_pkg::timer_value_t value_wr,    // Data for the load
  input  logic                    ext_in,      // Async count input
  output timer_pkg::timer_value_t value,       // Current count
  output logic                    wrap         // One-cycle pulse
);

  logic [1:0] ext_sync;                        // Two-flop synchronizer
  logic       ext_dly;                         // Edge register, previous level
  logic       ext_rise;                        // Rising edge seen
  logic       tick;                            // Decrement request

  // ----------------------------------------
  // External input synchronizer and edge detect
  always_ff @(posedge pclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ext_sync <= '0;
      ext_dly  <= 1'b0;
    end
    else
    begin
      ext_sync <= {ext_sync[0], ext_in};
      ext_dly  <= ext_sync[1];
    end
  end

  assign ext_rise = ext_sync[1] & ~ext_dly;
  assign tick     = ctrl.enable & (ctrl.ext_sel ? ext_rise : 1'b1);

  // ----------------------------------------
  // Down-counter, bus load has priority
  always_ff @(posedge pclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      value <= '0;
      wrap  <= 1'b0;
    end
    else
    begin
      wrap <= 1'b0;
      if (value_load)
        value <= value_wr;
      else if (tick && value == '0)
      begin
        value <= reload;                       // Passed zero, reload
        wrap  <= 1'b1;
      end
      else if (tick)
        value <= value - 1'b1;
    end
  end

  // Wrap only after an unloaded tick at zero
  a_wrap_cause : assert property (@(posedge pclk) disable iff (!arst_n)
    wrap |-> $past(tick && !value_load && value == '0));

endmodule

/* timer_regs.sv */
// Writes land at the end of the access phase; undefined offsets read zero and ignore writes
`timescale 1ns/1ns
`include "subsys_defines.svh"

module timer_regs (
  input  logic                    pclk,        // Clock
  input  logic                    arst_n,      // Async reset, active low
  input  logic                    sel,         // Timer selected
  input  logic                    penable,     // Access phase
  input  logic                    pwrite,      // Write transfer
  input  logic [`SUBSYS_OFFSET_MSB-`SUBSYS_OFFSET_LSB:0] offset,  // Word offset
  input  apb_pkg::apb_data_t      wr_data,     // Write data
  output apb_pkg::apb_data_t      rd_data,     // Read data, comb
  output timer_pkg::timer_ctrl_t  ctrl,        // CTRL register
  output timer_pkg::timer_value_t reload,      // RELOAD register
  output logic                    value_load,  // VALUE write strobe
  output timer_pkg::timer_value_t value_wr,    // VALUE write data
  input  timer_pkg::timer_value_t value,       // Live count
  input  logic                    wrap,        // Wrap pulse from counter
  output logic                    irq          // Interrupt flag
);
  import timer_pkg::*;

  logic wr_en;                                 // Completing write
  logic rd_en;                                 // Read transfer in progress

  assign wr_en = sel & penable & pwrite;
  assign rd_en = sel & ~pwrite;

  // ----------------------------------------
  // Register writes
  always_ff @(posedge pclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl   <= '0;
      reload <= '0;
      irq    <= 1'b0;
    end
    else
    begin
      if (wr_en && offset == `TIMER_CTRL_OFS)
        ctrl <= wr_data[$bits(timer_ctrl_t)-1:0];
      if (wr_en && offset == `TIMER_RELOAD_OFS)
        reload <= wr_data;
      if (wrap && ctrl.irq_en)
        irq <= 1'b1;                           // New wrap wins over a clear
      else if (wr_en && offset == `TIMER_INTCLR_OFS && wr_data[0])
        irq <= 1'b0;                           // Write 1 to clear
    end
  end

  // VALUE lives in the counter, forward as a load
  assign value_load = wr_en && (offset == `TIMER_VALUE_OFS);
  assign value_wr   = wr_data;

  // ----------------------------------------
  // Read path
  always_comb
  begin
    rd_data = '0;                              // Undefined offsets and idle
    if (rd_en)
    begin
      case (offset)
        `TIMER_CTRL_OFS:   rd_data[$bits(timer_ctrl_t)-1:0] = ctrl;
        `TIMER_VALUE_OFS:  rd_data = value;
        `TIMER_RELOAD_OFS: rd_data = reload;
        `TIMER_INTCLR_OFS: rd_data[0] = irq;   // Flag readback
        default:           rd_data = '0;
      endcase
    end
  end

  // Access phase only after this timer's own setup phase
  a_access_after_setup : assert property (@(posedge pclk) disable iff (!arst_n)
    (sel && penable) |-> $past(sel && !penable));

  // Flag only rises while interrupts were enabled
  a_irq_needs_en : assert property (@(posedge pclk) disable iff (!arst_n)
    $rose(irq) |-> $past(ctrl.irq_en));

endmodule

/* apb_timer.sv */
// One timer on the shared pclk; ext_in is synchronized inside, irq is a level until cleared
`timescale 1ns/1ns
`include "subsys_defines.svh"

module apb_timer (
  input  logic               pclk,       // Clock
  input  logic               arst_n,     // Async reset, active low
  input  logic               sel,        // This timer selected
  input  logic               penable,    // Access phase
  input  logic               pwrite,     // Write transfer
  input  logic [`SUBSYS_OFFSET_MSB-`SUBSYS_OFFSET_LSB:0] offset,  // Word offset
  input  apb_pkg::apb_data_t wr_data,    // Write data
  output apb_pkg::apb_data_t rd_data,    // Read data
  input  logic               ext_in,     // Async count input
  output logic               irq         // Level interrupt
);
  import timer_pkg::*;

  timer_ctrl_t  ctrl;                    // Enable, mode, irq enable
  timer_value_t reload;                  // Reload on wrap
  timer_value_t value;                   // Live count
  timer_value_t value_wr;                // VALUE write data
  logic         value_load;              // VALUE write strobe
  logic         wrap;                    // Count passed zero

  // ----------------------------------------
  // Registers and bus side
  timer_regs u_regs (
    .pclk       (pclk),
    .arst_n     (arst_n),
    .sel        (sel),
    .penable    (penable),
    .pwrite     (pwrite),
    .offset     (offset),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .ctrl       (ctrl),
    .reload     (reload),
    .value_load (value_load),
    .value_wr   (value_wr),
    .value      (value),
    .wrap       (wrap),
    .irq        (irq)
  );

  // Counting side
  timer_counter u_counter (
    .pclk       (pclk),
    .arst_n     (arst_n),
    .ctrl       (ctrl),
    .reload     (reload),
    .value_load (value_load),
    .value_wr   (value_wr),
    .ext_in     (ext_in),
    .value      (value),
    .wrap       (wrap)
  );

endmodule

/* apb_subsystem.sv */
// Host drives APB on pclk directly; pready is always high and ext_in may be fully asynchronous
`timescale 1ns/1ns
`include "subsys_defines.svh"

module apb_subsystem (
  input  logic                pclk,          // Bus and timer clock
  input  logic                arst_n,        // Async reset, active low
  input  logic                psel,          // Subsystem select from host
  input  logic                penable,       // Access phase
  input  logic                pwrite,        // 1 write, 0 read
  input  apb_pkg::apb_addr_t  paddr,         // Byte address
  input  apb_pkg::apb_data_t  pwdata,        // Write data
  output apb_pkg::apb_data_t  prdata,        // Muxed read data
  output logic                pready,        // Tied high
  output logic                pslverr,       // Unmapped access
  input  logic [1:0]          ext_in,        // External count inputs, one per timer
  output timer_pkg::irq_vec_t irq            // Level interrupts
);
  import apb_pkg::*;

  periph_sel_t sel;                          // One-hot peripheral select
  apb_data_t   timer0_rd_data;               // Timer 0 read path
  apb_data_t   timer1_rd_data;               // Timer 1 read path

  assign pready = 1'b1;                      // All peripherals zero-wait

  // ----------------------------------------
  // Address decode
  apb_decoder u_decoder (
    .psel   (psel),
    .region (paddr[`SUBSYS_REGION_MSB:`SUBSYS_REGION_LSB]),
    .sel    (sel)
  );

  // ----------------------------------------
  // Timers
  apb_timer timer0 (
    .pclk    (pclk),
    .arst_n  (arst_n),
    .sel     (sel[PSEL_TIMER0]),
    .penable (penable),
    .pwrite  (pwrite),
    .offset  (paddr[`SUBSYS_OFFSET_MSB:`SUBSYS_OFFSET_LSB]),
    .wr_data (pwdata),
    .rd_data (timer0_rd_data),
    .ext_in  (ext_in[0]),
    .irq     (irq[0])                        // Vector bit 0
  );

  apb_timer timer1 (
    .pclk    (pclk),
    .arst_n  (arst_n),
    .sel     (sel[PSEL_TIMER1]),
    .penable (penable),
    .pwrite  (pwrite),
    .offset  (paddr[`SUBSYS_OFFSET_MSB:`SUBSYS_OFFSET_LSB]),
    .wr_data (pwdata),
    .rd_data (timer1_rd_data),
    .ext_in  (ext_in[1]),
    .irq     (irq[1])                        // Vector bit 1
  );

  // ----------------------------------------
  // Read data and error return
  apb_slave_mux u_mux (
    .penable        (penable),
    .sel            (sel),
    .timer0_rd_data (timer0_rd_data),
    .timer1_rd_data (timer1_rd_data),
    .prdata         (prdata),
    .pslverr        (pslverr)
  );

endmodule

/* tb_apb_subsystem.sv */
// Run from the project root; cases come from tb_cases.txt, each transfer is setup, access, idle
`timescale 1ns/1ns

module tb_apb_subsystem;
  import apb_pkg::*;
  import timer_pkg::*;

  localparam int       MAX_CASES   = 64;     // Case file capacity
  localparam int       CASE_CYCLES = 40;     // Timeout budget per case
  localparam bit [3:0] OP_WRITE    = 4'h0;
  localparam bit [3:0] OP_READ     = 4'h1;
  localparam bit [3:0] OP_PULSE    = 4'h2;   // Rising pulses on ext_in
  localparam bit [3:0] OP_IDLE     = 4'h3;
  localparam bit [3:0] OP_POLL     = 4'h4;   // Read INTCLR until the flag sets
  localparam bit [3:0] OP_END      = 4'hf;

  logic        pclk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic [1:0]  ext_in;
  irq_vec_t    irq;

  logic [31:0] case_mem [0:4*MAX_CASES-1];   // Op, addr, data, flag per case
  logic [31:0] lfsr;                         // Pulse gap generator state
  int          num_cases;
  int          cycle_limit;                  // Zero until cases are counted
  int          cycle_count;

  apb_subsystem UUT (
    .pclk    (pclk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ext_in  (ext_in),
    .irq     (irq)
  );

  always #50 pclk = ~pclk;                   // 100 ns period

  // ----------------------------------------
  // Timeout
  always @(posedge pclk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("Run stopped after %0d cycles with cases still pending", cycle_count);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // Galois LFSR, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val  = (val << 1) | int'(lfsr[0]);     // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // ----------------------------------------
  // Compare tasks
  task automatic check_data(input apb_data_t got, input apb_data_t exp, input int idx);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: case %0d prdata 0x%08h, expected 0x%08h", $time, idx, got, exp);
      $display("Test failed");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input int idx);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: case %0d pslverr %b, expected %b", $time, idx, got, exp);
      $display("Test failed");
      $fatal(1, "error response mismatch");
    end
  endtask

  task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input int idx);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: case %0d irq %b, expected %b", $time, idx, got, exp);
      $display("Test failed");
      $fatal(1, "interrupt vector mismatch");
    end
  endtask

  // ----------------------------------------
  // APB driver, one idle cycle after each access
  task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
    @(posedge pclk);
    psel    <= 1'b1;                         // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge pclk);
    penable <= 1'b1;                         // Access phase
    @(negedge pclk);
    while (pready !== 1'b1)
      @(negedge pclk);
    rdata = prdata;                          // Stable mid-cycle
    err   = pslverr;
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic ext_pulses(input logic [1:0] mask, input int count);
    int gap;
    for (int n = 0; n < count; n++)
    begin
      @(posedge pclk);
      ext_in <= ext_in | mask;
      repeat (3) @(posedge pclk);            // High for three cycles
      ext_in <= ext_in & ~mask;
      draw_bits(2, gap);
      repeat (2 + gap) @(posedge pclk);      // Low three cycles plus 0 to 3
    end
  endtask

  task automatic poll_flag(input apb_addr_t addr, input int max_polls, input int idx);
    apb_data_t rdata;
    logic      err;
    int        polls;
    polls = 0;
    rdata = '0;
    while (rdata[0] !== 1'b1)
    begin
      if (polls >= max_polls)
      begin
        $display("Interrupt flag of case %0d was not set within %0d polls", idx, max_polls);
        $display("Test failed");
        $fatal(1, "flag poll limit");
      end
      apb_transfer(1'b0, addr, '0, rdata, err);
      check_err(err, 1'b0, idx);
      polls++;
    end
  endtask

  // ----------------------------------------
  // Case runner
  initial
  begin
    int        idx;
    logic [3:0] op;
    apb_addr_t addr;
    apb_data_t data;
    logic [31:0] flag;
    apb_data_t rdata;
    logic      err;
    pclk        = 1'b0;
    arst_n      = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    ext_in      = '0;
    lfsr        = 32'h6c34;
    cycle_count = 0;
    cycle_limit = 0;
    num_cases   = 0;
    $readmemh("tb_cases.txt", case_mem);
    while (num_cases < MAX_CASES && case_mem[4*num_cases] !== {28'd0, OP_END})
      num_cases++;
    if (num_cases == 0 || num_cases == MAX_CASES)
    begin
      $display("Case file tb_cases.txt is missing, empty or has no end marker");
      $display("Test failed");
      $fatal(1, "bad case file");
    end
    cycle_limit = (num_cases + 1) * CASE_CYCLES;   // Extra slot covers reset
    repeat (8) @(posedge pclk);
    arst_n <= 1'b1;
    for (idx = 0; idx < num_cases; idx++)
    begin
      op   = case_mem[4*idx][3:0];
      addr = apb_addr_t'(case_mem[4*idx+1]);
      data = case_mem[4*idx+2];
      flag = case_mem[4*idx+3];
      case (op)
        OP_WRITE:
        begin
          apb_transfer(1'b1, addr, data, rdata, err);
          check_err(err, flag[0], idx);
        end
        OP_READ:
        begin
          apb_transfer(1'b0, addr, '0, rdata, err);
          check_data(rdata, data, idx);
          check_err(err, flag[0], idx);
        end
        OP_PULSE:
        begin
          ext_pulses(addr[1:0], data);
          @(negedge pclk);
          check_irq(irq, irq_vec_t'(flag), idx);
        end
        OP_IDLE:
        begin
          repeat (data) @(posedge pclk);
          @(negedge pclk);
          check_irq(irq, irq_vec_t'(flag), idx);
        end
        OP_POLL:
        begin
          poll_flag(addr, data, idx);
          @(negedge pclk);
          check_irq(irq, irq_vec_t'(flag), idx);
        end
        default:
        begin
          $display("Case %0d has an unknown opcode %h", idx, op);
          $display("Test failed");
          $fatal(1, "bad opcode");
        end
      endcase
    end
    $display("Test passed");
    $finish;
  end

endmodule

/* tb_cases.txt */
// op: 0 write, 1 read, 2 ext pulses, 3 idle, 4 poll INTCLR, f end of cases
// addr: bus address, or ext_in mask for pulses / data: write data, read value, count / flag: pslverr or irq
// Reset values of both timers
1 0000 00000000 0
1 0004 00000000 0
1 0008 00000000 0
1 000c 00000000 0
1 1000 00000000 0
1 1004 00000000 0
1 1008 00000000 0
1 100c 00000000 0
3 0000 00000004 0
// Register readback and undefined offset
0 0008 0000000a 0
1 0008 0000000a 0
0 1008 12345678 0
1 1008 12345678 0
0 0004 00000001 0
1 0004 00000001 0
0 0010 deadbeef 0
1 0010 00000000 0
// Unmapped regions
0 2000 cafef00d 1
1 f004 00000000 1
// Timer 0 external mode with irq_en
0 0000 00000007 0
1 0000 00000007 0
2 0001 00000001 0
3 0000 00000004 0
1 0004 00000000 0
2 0001 00000001 1
3 0000 00000004 1
1 0004 0000000a 0
1 000c 00000001 0
2 0001 00000003 1
3 0000 00000004 1
1 0004 00000007 0
1 1004 00000000 0
0 000c 00000001 0
3 0000 00000004 0
// Wrap with irq_en clear
0 0000 00000003 0
0 0004 00000000 0
2 0001 00000001 0
3 0000 00000004 0
1 0004 0000000a 0
// Timer 1 internal mode, reload 16, at most 11 polls
0 1008 00000010 0
0 1000 00000001 0
0 1000 00000005 0
4 100c 0000000b 2
0 1000 00000000 0
0 100c 00000001 0
3 0000 00000004 0
f 0000 00000000 0

/* list.f */
+incdir+.
apb_pkg.sv
timer_pkg.sv
apb_decoder.sv
apb_slave_mux.sv
timer_counter.sv
timer_regs.sv
apb_timer.sv
apb_subsystem.sv
tb_apb_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module tb_apb_subsystem -f list.f > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/Vtb_apb_subsystem > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Test passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
